/* verilog/rvPkg.sv */
// RV32I Shared Types
package rvPkg;

    // ----------------------------------------
    // Major opcodes
    // ----------------------------------------
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OPIMM  = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeT;

    // ----------------------------------------
    // ALU operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10     // Forwards operand B, used by LUI
    } aluOpT;

    // ----------------------------------------
    // Immediate formats
    // ----------------------------------------
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immTypeT;

    // Operand and next-pc selections
    typedef enum logic {
        A_RS1 = 1'b0,
        A_PC  = 1'b1
    } aSrcT;

    typedef enum logic [1:0] {
        B_RS2  = 2'd0,
        B_IMM  = 2'd1,
        B_FOUR = 2'd2         // Link value pc+4 for JAL and JALR
    } bSrcT;

    typedef enum logic {
        BASE_PC  = 1'b0,
        BASE_RS1 = 1'b1
    } pcBaseT;

endpackage

/* verilog/alu.sv */
// Integer ALU
`timescale 1ns/1ns

module alu
    import rvPkg::*;
(
    input  aluOpT       aluOp,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        lessFlag,
    output logic        zeroFlag
);

    logic [4:0] shamt;
    logic       signedLess;
    logic       unsignedLess;

    assign shamt        = b[4:0];
    assign signedLess   = ($signed(a) < $signed(b));
    assign unsignedLess = (a < b);

    // ----------------------------------------
    // Operation select
    // ----------------------------------------
    always_comb begin
        case (aluOp)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SLT: begin
                result = {31'd0, signedLess};
            end
            ALU_SLTU: begin
                result = {31'd0, unsignedLess};
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_SRA: begin
                result = $signed(a) >>> shamt; // Keeps the sign of a
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_AND: begin
                result = a & b;
            end
            default: begin
                result = b;
            end
        endcase
    end

    // Branches pick signedness through the op they select
    assign lessFlag = (aluOp == ALU_SLTU) ? unsignedLess : signedLess;
    assign zeroFlag = (result == 32'd0);

endmodule

/* verilog/immDecoder.sv */
// Immediate Decoder
`timescale 1ns/1ns

module immDecoder
    import rvPkg::*;
(
    input  logic [31:0] cmd,
    input  immTypeT     immType,
    output logic [31:0] imm
);

    logic sign;

    assign sign = cmd[31];

    always_comb begin
        case (immType)
            IMM_S: begin
                imm = {{20{sign}}, cmd[31:25], cmd[11:7]};
            end
            IMM_B: begin
                imm = {{19{sign}}, cmd[31], cmd[7], cmd[30:25], cmd[11:8], 1'b0};
            end
            IMM_U: begin
                imm = {cmd[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, cmd[31], cmd[19:12], cmd[20], cmd[30:21], 1'b0};
            end
            default: begin
                imm = {{20{sign}}, cmd[31:20]}; // I format
            end
        endcase
    end

endmodule

/* verilog/registerFile.sv */
// Integer Register File
`timescale 1ns/1ns

module registerFile (
    input  logic        clk,
    input  logic [4:0]  raddrA,
    input  logic [4:0]  raddrB,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    input  logic        wen,
    output logic [31:0] rdataA,
    output logic [31:0] rdataB
);

    logic [31:0] regs [32];

    // ----------------------------------------
    // Write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------
    // x0 reads as zero whatever the array holds
    assign rdataA = (raddrA == 5'd0) ? 32'd0 : regs[raddrA];
    assign rdataB = (raddrB == 5'd0) ? 32'd0 : regs[raddrB];

endmodule

/* verilog/controlUnit.sv */
// Instruction Decode Control
`timescale 1ns/1ns

module controlUnit
    import rvPkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  logic       lessFlag,
    input  logic       zeroFlag,
    output immTypeT    immType,
    output aSrcT       aSrc,
    output bSrcT       bSrc,
    output aluOpT      aluOp,
    output logic       regWrite,
    output pcBaseT     pcBase,
    output logic       pcJump
);

    opcodeT opc;
    aluOpT  arithOp;
    aluOpT  branchOp;
    logic   isOp;
    logic   branchValid;
    logic   flagHit;
    logic   branchTaken;

    assign opc  = opcodeT'(opcode);
    assign isOp = (opc == OPC_OP);

    // ----------------------------------------
    // OP and OP-IMM function decode
    // ----------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (isOp && funct7b5) ? ALU_SUB : ALU_ADD; // No SUBI in OP-IMM
            3'b001:  arithOp = ALU_SLL;
            3'b010:  arithOp = ALU_SLT;
            3'b011:  arithOp = ALU_SLTU;
            3'b100:  arithOp = ALU_XOR;
            3'b101:  arithOp = funct7b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arithOp = ALU_OR;
            default: arithOp = ALU_AND;
        endcase
    end

    // ----------------------------------------
    // Branch compare selection
    // ----------------------------------------
    always_comb begin
        case (funct3[2:1])
            2'b10:   branchOp = ALU_SLT;
            2'b11:   branchOp = ALU_SLTU;
            default: branchOp = ALU_SUB;  // BEQ and BNE test the difference for zero
        endcase
    end

    assign branchValid = (funct3[2:1] != 2'b01);
    assign flagHit     = (funct3[2:1] == 2'b00) ? zeroFlag : lessFlag;
    assign branchTaken = branchValid && (flagHit ^ funct3[0]); // Odd funct3 negates the test

    always_comb begin
        immType  = IMM_I;
        aSrc     = A_RS1;
        bSrc     = B_RS2;
        aluOp    = ALU_ADD;
        regWrite = 1'b0;
        pcBase   = BASE_PC;
        case (opc)
            OPC_LUI: begin
                immType  = IMM_U;
                bSrc     = B_IMM;
                aluOp    = ALU_PASSB;
                regWrite = 1'b1;
            end
            OPC_AUIPC: begin
                immType  = IMM_U;
                aSrc     = A_PC;
                bSrc     = B_IMM;
                regWrite = 1'b1;
            end
            OPC_JAL: begin
                immType  = IMM_J;
                aSrc     = A_PC;
                bSrc     = B_FOUR;
                regWrite = 1'b1;
            end
            OPC_JALR: begin
                aSrc     = A_PC;
                bSrc     = B_FOUR;
                regWrite = 1'b1;
                pcBase   = BASE_RS1;
            end
            OPC_BRANCH: begin
                immType  = IMM_B;
                aluOp    = branchOp;
            end
            OPC_OPIMM: begin
                bSrc     = B_IMM;
                aluOp    = arithOp;
                regWrite = 1'b1;
            end
            OPC_OP: begin
                aluOp    = arithOp;
                regWrite = 1'b1;
            end
            default: ; // Anything else retires as a no-op
        endcase
    end

    // Kept apart from the decode block so the flags never feed back into aluOp
    assign pcJump = (opc == OPC_JAL) || (opc == OPC_JALR) ||
                    ((opc == OPC_BRANCH) && branchTaken);

endmodule

/* verilog/pcUnit.sv */
// Program Counter
`timescale 1ns/1ns

module pcUnit
    import rvPkg::*;
#(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        pcJump,
    input  pcBaseT      pcBase,
    input  logic [31:0] rs1,
    input  logic [31:0] imm,
    output logic [31:0] pc
);

    logic [31:0] base;
    logic [31:0] target;
    logic [31:0] nextPc;

    assign base   = (pcBase == BASE_RS1) ? rs1 : pc;
    assign target = base + imm;

    // JALR drops bit 0 of its target
    assign nextPc = pcJump ? {target[31:1], target[0] & (pcBase == BASE_PC)} : pc + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* verilog/cpu.sv */
// Single-Cycle RV32I Core
`timescale 1ns/1ns

module cpu
    import rvPkg::*;
#(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic [31:0] cmd,
    output logic [31:0] pc,
    output logic        wbEn,
    output logic [4:0]  wbAddr,
    output logic [31:0] wbData
);

    logic [4:0]  rs1Addr;
    logic [4:0]  rs2Addr;
    logic [4:0]  rdAddr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] imm;
    logic [31:0] aluA;
    logic [31:0] aluB;

    immTypeT immType;
    aSrcT    aSrc;
    bSrcT    bSrc;
    aluOpT   aluOp;
    pcBaseT  pcBase;
    logic    regWrite;
    logic    pcJump;
    logic    lessFlag;
    logic    zeroFlag;

    // ----------------------------------------
    // Field extraction
    // ----------------------------------------
    assign rs1Addr = cmd[19:15];
    assign rs2Addr = cmd[24:20];
    assign rdAddr  = cmd[11:7];

    controlUnit cu (
        .opcode   (cmd[6:0]),
        .funct3   (cmd[14:12]),
        .funct7b5 (cmd[30]),
        .lessFlag (lessFlag),
        .zeroFlag (zeroFlag),
        .immType  (immType),
        .aSrc     (aSrc),
        .bSrc     (bSrc),
        .aluOp    (aluOp),
        .regWrite (regWrite),
        .pcBase   (pcBase),
        .pcJump   (pcJump)
    );

    immDecoder immDec (
        .cmd     (cmd),
        .immType (immType),
        .imm     (imm)
    );

    registerFile regFile (
        .clk    (clk),
        .raddrA (rs1Addr),
        .raddrB (rs2Addr),
        .waddr  (rdAddr),
        .wdata  (wbData),
        .wen    (wbEn),
        .rdataA (rs1Data),
        .rdataB (rs2Data)
    );

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    assign aluA = (aSrc == A_PC) ? pc : rs1Data;

    always_comb begin
        case (bSrc)
            B_IMM:   aluB = imm;
            B_FOUR:  aluB = 32'd4;
            default: aluB = rs2Data;
        endcase
    end

    alu alu0 (
        .aluOp    (aluOp),
        .a        (aluA),
        .b        (aluB),
        .result   (wbData),
        .lessFlag (lessFlag),
        .zeroFlag (zeroFlag)
    );

    pcUnit #(
        .resetPc (resetPc)
    ) pcU (
        .clk    (clk),
        .rstN   (rstN),
        .pcJump (pcJump),
        .pcBase (pcBase),
        .rs1    (rs1Data),
        .imm    (imm),
        .pc     (pc)
    );

    // Write-back never targets x0 and stays quiet while reset is held
    assign wbEn   = regWrite && (rdAddr != 5'd0) && rstN;
    assign wbAddr = rdAddr;

endmodule

/* test/cpuAsserts.sv */
// Core Write-Back Assertions
`timescale 1ns/1ns

module cpuAsserts (
    input logic        clk,
    input logic        rstN,
    input logic [31:0] pc,
    input logic        wbEn,
    input logic [4:0]  wbAddr
);

    // Reset must hold the register file still whatever cmd carries
    noWriteInReset: assert property (@(posedge clk) !rstN |-> !wbEn)
        else $error("write-back enabled while reset is held");

    noWriteToX0: assert property (@(posedge clk) wbEn |-> (wbAddr != 5'd0))
        else $error("write-back addressed to x0");

    pcAligned: assert property (@(posedge clk) rstN |-> (pc[1:0] == 2'b00))
        else $error("pc is not word aligned");

endmodule

/* test/cpuChecker.sv */
// Write-Back and PC Checker
`timescale 1ns/1ns

module cpuChecker
    import rvPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        checkEn,
    input  logic [31:0] pc,
    input  logic        wbEn,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData,
    input  logic [31:0] expPc,
    input  logic        expWbEn,
    input  logic [4:0]  expWbAddr,
    input  logic [31:0] expWbData,
    output int          errorCount
);

    int errors;
    int checkCount;

    initial begin
        errors     = 0;
        checkCount = 0;
    end

    assign errorCount = errors;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch %s got %h exp %h", name, got, exp);
        end
    endtask

    // ----------------------------------------
    // Sampled before the edge updates pc and the register file
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rstN) begin
            if (wbEn !== 1'b0) begin
                errors++;
                $display("write-back was enabled while reset was held");
            end
        end else if (checkEn) begin
            checkCount++;
            compare("pc", pc, expPc);
            compare("wbEn", {31'd0, wbEn}, {31'd0, expWbEn});
            if (expWbEn) begin  // Address and data only matter for a real write
                compare("wbAddr", {27'd0, wbAddr}, {27'd0, expWbAddr});
                compare("wbData", wbData, expWbData);
            end
        end
    end

    task automatic printSummary();
        $display("checker: %0d cycles compared, %0d errors", checkCount, errors);
    endtask

endmodule

/* test/cpuTb.sv */
// Core Testbench
`timescale 1ns/1ns

module cpuTb;

    localparam int maxWords      = 1024;
    localparam int timeoutCycles = 2000;

    logic        clk;
    logic        rstN;
    logic [31:0] cmd;
    logic [31:0] pc;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic        checkEn;
    logic        stimDone;
    logic        stimOk;
    logic [31:0] expPc;
    logic        expWbEn;
    logic [4:0]  expWbAddr;
    logic [31:0] expWbData;
    logic [31:0] stim [maxWords];
    int          errorCount;
    int          recCount;
    int          waited;

    cpu #(.resetPc(32'h0000_0000)) u_dut (
        .clk(clk), .rstN(rstN), .cmd(cmd),
        .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
    );

    cpuChecker chk (
        .clk(clk), .rstN(rstN), .checkEn(checkEn),
        .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .expPc(expPc), .expWbEn(expWbEn), .expWbAddr(expWbAddr), .expWbData(expWbData),
        .errorCount(errorCount)
    );

    bind cpu cpuAsserts assertsInst (
        .clk(clk), .rstN(rstN), .pc(pc), .wbEn(wbEn), .wbAddr(wbAddr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Word 0 is the record count, then five words per record
    task automatic loadRecord(input int idx);
        int base;
        base      = 1 + 5 * idx;
        cmd       = stim[base];
        expPc     = stim[base + 1];
        expWbEn   = stim[base + 2][0];
        expWbAddr = stim[base + 3][4:0];
        expWbData = stim[base + 4];
    endtask

    // ----------------------------------------
    // Stimulus, applied on falling edges
    // ----------------------------------------
    initial begin
        rstN      = 1'b0;
        cmd       = 32'h00100f93;  // A live write to x31 that reset has to suppress
        checkEn   = 1'b0;
        stimDone  = 1'b0;
        expPc     = 32'd0;
        expWbEn   = 1'b0;
        expWbAddr = 5'd0;
        expWbData = 32'd0;
        $readmemh("test/cpu_stim.txt", stim);
        recCount = stim[0];
        stimOk   = (recCount > 0) && (recCount * 5 < maxWords);
        if (!stimOk) begin
            $display("stim file holds no valid record count");
        end
        repeat (10) @(negedge clk);
        rstN = 1'b1;
        if (stimOk) begin
            for (int i = 0; i < recCount; i++) begin
                loadRecord(i);
                checkEn = 1'b1;
                @(negedge clk);
            end
        end
        checkEn  = 1'b0;
        cmd      = 32'd0;
        stimDone = 1'b1;
    end

    initial begin
        waited = 0;
        while (stimDone !== 1'b1 && waited < timeoutCycles) begin
            @(posedge clk);
            waited++;
        end
        if (stimDone !== 1'b1) begin
            $display("stimulus did not finish in time");
            $display("Errors found");
        end else begin
            chk.printSummary();
            if (errorCount == 0 && stimOk) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
        end
        $finish;
    end

endmodule

/* test/cpu_stim.txt */
// Word 0: record count. Then one record per cycle, all hex:
// instruction, expected pc, expected wbEn, expected wbAddr, expected wbData
30
00500093 00000000 1 01 00000005
ffd00113 00000004 1 02 fffffffd
00708013 00000008 0 00 00000000
123451b7 0000000c 1 03 12345000
00001217 00000010 1 04 00001010
abcde037 00000014 0 00 00000000
001002b3 00000018 1 05 00000005
40208333 0000001c 1 06 00000008
006093b3 00000020 1 07 00000500
00112433 00000024 1 08 00000001
001134b3 00000028 1 09 00000000
00314533 0000002c 1 0a edcbaffd
001155b3 00000030 1 0b 07ffffff
40115633 00000034 1 0c ffffffff
0030e6b3 00000038 1 0d 12345005
00317733 0000003c 1 0e 12345000
ffe12793 00000040 1 0f 00000001
fff0b813 00000044 1 10 00000001
fff0c893 00000048 1 11 fffffffa
0f00e913 0000004c 1 12 000000f5
7f017993 00000050 1 13 000007f0
00409a13 00000054 1 14 00000050
01c15a93 00000058 1 15 0000000f
40115b13 0000005c 1 16 fffffffe
003b0b93 00000060 1 17 00000001
00508463 00000064 0 00 00000000
00208463 0000006c 0 00 00000000
00209463 00000070 0 00 00000000
00509463 00000078 0 00 00000000
00114463 0000007c 0 00 00000000
0020c463 00000084 0 00 00000000
0020d463 00000088 0 00 00000000
00115463 00000090 0 00 00000000
0020e463 00000094 0 00 00000000
00116463 0000009c 0 00 00000000
00117463 000000a0 0 00 00000000
0020f463 000000a8 0 00 00000000
00c00c6f 000000ac 1 18 000000b0
001c0ce7 000000b8 1 19 000000bc
ffcc8d13 000000b0 1 1a 000000b8
0100006f 000000b4 0 00 00000000
ffc18de7 000000c4 1 1b 000000c8
800ffe6f 12344ffc 1 1c 12345000
fffffe97 12343ffc 1 1d 12342ffc
41ce8f33 12344000 1 1e ffffdffc
01e06fb3 12344004 1 1f ffffdffc
0000a083 12344008 0 00 00000000
00108093 1234400c 1 01 00000006

/* flist.f */
verilog/rvPkg.sv
verilog/alu.sv
verilog/immDecoder.sv
verilog/registerFile.sv
verilog/controlUnit.sv
verilog/pcUnit.sv
verilog/cpu.sv
test/cpuAsserts.sv
test/cpuChecker.sv
test/cpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f flist.f -o cpuSim

out=$(./obj_dir/cpuSim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
